//--- bench/tb_lrelu_top.sv
module tb_lrelu_top;

    localparam int          UNITS       = 2;
    localparam int          MEMBERS     = 4;
    localparam int          ITERS       = 6;  // ready stays high for the first half only
    localparam int          BEATS       = 4;  // wide data beats per iteration
    localparam int          TOTAL_BEATS = ITERS * BEATS * MEMBERS;  // narrow output beats
    localparam int          CYCLE_LIMIT = 4 * TOTAL_BEATS + 200;
    localparam logic [31:0] SEED        = 32'hf06a5e7d;

    typedef lrelu_pkg::acc_t [MEMBERS*UNITS-1:0] wide_t;
    typedef lrelu_pkg::out_t [UNITS-1:0]         narrow_t;

    logic    aclk;
    logic    arst_n;
    logic    s_axis_tvalid;
    logic    s_axis_tready;
    wide_t   s_axis_tdata;
    logic    s_axis_tlast;
    logic    m_axis_tvalid;
    logic    m_axis_tready = 1'b1;
    narrow_t m_axis_tdata;
    logic    m_axis_tlast;

    narrow_t                       exp_data_q[$];  // expected narrow beats in output order
    logic                          exp_last_q[$];
    narrow_t                       exp_data;       // queue head as the assertions see it
    logic                          exp_last;
    int                            exp_cnt    = 0;
    int                            out_cnt    = 0;
    logic                          expect_cfg = 1'b1;  // next input beat is a config beat
    logic                          draining   = 1'b0;  // set from the input tlast to the output tlast
    lrelu_pkg::acc_t   [UNITS-1:0] ref_bias;
    lrelu_pkg::scale_t [UNITS-1:0] ref_scale;
    lrelu_pkg::shift_t             ref_shift;
    logic [31:0]                   data_state;
    logic [31:0]                   ready_state;
    logic                          bp_phase   = 1'b0;
    int                            cycle_cnt;

    // with scale 4 and shift 2 these map to 100 -5 127 -128 55 -1 127 -128
    lrelu_pkg::acc_t directed_words [MEMBERS*UNITS] =
        '{100, -40, 2000, -5000, 55, -8, 127, -1024};

    axis_lrelu_top #(.UNITS(UNITS), .MEMBERS(MEMBERS)) uut (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tlast  (s_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // bias add, scale, shift, then a 1/8 slope below zero and a clamp to a signed byte
    function automatic lrelu_pkg::out_t expected_word(input lrelu_pkg::acc_t x,
                                                      input lrelu_pkg::acc_t b,
                                                      input lrelu_pkg::scale_t sc,
                                                      input lrelu_pkg::shift_t sh);
        int v;
        v = (int'(x) + int'(b)) * int'(sc);  // int holds 17 bits times 8 bits easily
        v = v >>> sh;
        if (v < 0) begin
            v = v >>> lrelu_pkg::LEAK_SHIFT;
        end
        if (v > 127) begin
            return 8'sh7f;
        end else if (v < -128) begin
            return 8'sh80;
        end
        return v[7:0];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string test, input logic [63:0] expected,
                                  input logic [63:0] actual);
        abort_run($sformatf("ERR %s: expected %0h, actual %0h", test, expected, actual));
    endtask

    // fills every word from the data generator
    task automatic random_wide(output wide_t b);
        for (int w = 0; w < MEMBERS * UNITS; w++) begin
            data_state = lcg(data_state);
            b[w]       = data_state[31:16];  // upper bits of an lcg are the better ones
        end
    endtask

    // starts after a posedge and returns at the edge where the beat was taken
    task automatic send_beat(input wide_t d, input logic l);
        @(negedge aclk);
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = d;
        s_axis_tlast  = l;
        @(posedge aclk);
        while (!s_axis_tready) @(posedge aclk);
    endtask

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        abort_run("timeout: the output stream did not finish within the cycle limit");
    end

    // the output is ready about three cycles in four during the backpressure half
    always @(negedge aclk) begin
        if (bp_phase) begin
            ready_state   = lcg(ready_state);
            m_axis_tready = (ready_state[21:20] != 2'b00);
        end else begin
            m_axis_tready = 1'b1;
        end
    end

    // the reference model pops before it pushes since both can happen on one edge
    always @(posedge aclk) begin : model
        narrow_t beat;
        if (arst_n) begin
            if (m_axis_tvalid && m_axis_tready) begin
                out_cnt++;
                if (m_axis_tlast) begin
                    draining = 1'b0;  // iteration has left the top
                end
                if (exp_data_q.size() > 0) begin
                    void'(exp_data_q.pop_front());
                    void'(exp_last_q.pop_front());
                end
            end
            if (s_axis_tvalid && s_axis_tready) begin
                if (expect_cfg) begin
                    for (int u = 0; u < UNITS; u++) begin
                        ref_bias[u]  = s_axis_tdata[u];
                        ref_scale[u] = s_axis_tdata[UNITS+u][7:0];
                    end
                    ref_shift  = s_axis_tdata[2*UNITS][3:0];
                    expect_cfg = 1'b0;
                end else begin
                    for (int m = 0; m < MEMBERS; m++) begin
                        for (int u = 0; u < UNITS; u++) begin
                            beat[u] = expected_word(s_axis_tdata[m*UNITS+u], ref_bias[u],
                                                    ref_scale[u], ref_shift);
                        end
                        exp_data_q.push_back(beat);
                        exp_last_q.push_back(s_axis_tlast && (m == MEMBERS - 1));
                    end
                    if (s_axis_tlast) begin
                        expect_cfg = 1'b1;
                        draining   = 1'b1;
                    end
                end
            end
            exp_cnt = exp_data_q.size();
            if (exp_cnt > 0) begin
                exp_data = exp_data_q[0];
                exp_last = exp_last_q[0];
            end
        end
    end

    // reset may first reach the flops on the very first clock edge
    a_reset_idle: assert property (
        @(posedge aclk) (!arst_n && cycle_cnt > 0) |-> (!m_axis_tvalid && s_axis_tready)
    ) else value_mismatch("reset_idle", 64'h1,
                          {$sampled(m_axis_tvalid), $sampled(s_axis_tready)});

    a_reset_release: assert property (
        @(posedge aclk) $rose(arst_n) |-> (!m_axis_tvalid && s_axis_tready)
    ) else value_mismatch("reset_idle", 64'h1,
                          {$sampled(m_axis_tvalid), $sampled(s_axis_tready)});

    a_no_extra_beat: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (m_axis_tvalid && m_axis_tready) |-> (exp_cnt > 0)
    ) else abort_run("backpressure: output beat arrived with no input beat left to match it");

    a_requant_values: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (m_axis_tvalid && m_axis_tready && exp_cnt > 0) |-> (m_axis_tdata == exp_data)
    ) else value_mismatch("requant_values", $sampled(exp_data), $sampled(m_axis_tdata));

    a_width_and_last: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (m_axis_tvalid && m_axis_tready && exp_cnt > 0) |-> (m_axis_tlast == exp_last)
    ) else value_mismatch("width_and_last", $sampled(exp_last), $sampled(m_axis_tlast));

    a_reconfig_block: assert property (
        @(posedge aclk) disable iff (!arst_n) draining |-> !s_axis_tready
    ) else value_mismatch("reconfig_block", 64'h0, $sampled(s_axis_tready));

    a_backpressure: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (m_axis_tvalid && !m_axis_tready)
            |=> (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    ) else abort_run("backpressure: a stalled output beat changed or disappeared");

    initial begin
        wide_t beat;
        arst_n        = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tlast  = 1'b0;
        data_state    = SEED;
        ready_state   = ~SEED;  // separate stream for the ready pattern
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;
        for (int it = 0; it < ITERS; it++) begin
            bp_phase = (it >= ITERS / 2);
            random_wide(beat);
            if (it == 0) begin
                beat          = '0;  // gain of one so the directed words map as listed above
                beat[UNITS]   = 16'sd4;
                beat[UNITS+1] = 16'sd4;
                beat[2*UNITS] = 16'sd2;
            end
            send_beat(beat, 1'b0);
            for (int b = 0; b < BEATS; b++) begin
                random_wide(beat);
                if (it == 0 && b == 0) begin
                    for (int w = 0; w < MEMBERS * UNITS; w++) begin
                        beat[w] = directed_words[w];
                    end
                end
                send_beat(beat, b == BEATS - 1);
            end
        end
        @(negedge aclk);
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        while (out_cnt < TOTAL_BEATS) @(posedge aclk);
        repeat (10) @(posedge aclk);  // room for a stray extra beat to show up
        if (out_cnt != TOTAL_BEATS || exp_cnt != 0) begin
            abort_run("output beat count differs from the number of beats sent");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- tb.f
verilog/lrelu_pkg.sv
verilog/lrelu_beat_if.sv
verilog/lrelu_cfg_if.sv
verilog/lrelu_config_ctrl.sv
verilog/axis_dw_down.sv
verilog/lrelu_engine.sv
verilog/axis_reg_slice.sv
verilog/axis_lrelu_top.sv
bench/tb_lrelu_top.sv

//--- verilog/axis_dw_down.sv
module axis_dw_down #(
    parameter int UNITS   = lrelu_pkg::DEF_UNITS,
    parameter int MEMBERS = lrelu_pkg::DEF_MEMBERS
) (
    input  logic                                aclk,
    input  logic                                arst_n,
    input  logic                                s_valid,
    output logic                                s_ready,
    input  lrelu_pkg::acc_t [MEMBERS*UNITS-1:0] s_data,
    input  logic                                s_last,
    lrelu_beat_if.source                        m
);

    localparam int CNT_W   = (MEMBERS > 1) ? $clog2(MEMBERS) : 1;
    localparam int GROUP_W = UNITS * $bits(lrelu_pkg::acc_t);  // bits shifted out per beat

    lrelu_pkg::acc_t [MEMBERS*UNITS-1:0] buf_q;  // wide beat, current group in the lsbs
    logic                                full_q;
    logic                                last_q;  // wide beat arrived with tlast
    logic [CNT_W-1:0]                    cnt_q;   // member being presented
    logic                                s_fire;
    logic                                m_fire;
    logic                                final_member;

    assign s_ready      = !full_q;  // only one wide beat held at a time
    assign s_fire       = s_valid && s_ready;
    assign m_fire       = m.valid && m.ready;
    assign final_member = (cnt_q == CNT_W'(MEMBERS - 1));

    assign m.valid = full_q;
    assign m.data  = buf_q[UNITS-1:0];
    assign m.last  = last_q && final_member;  // only the last member carries tlast

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
            cnt_q  <= '0;
        end else if (s_fire) begin
            full_q <= 1'b1;  // first member valid the next cycle
            cnt_q  <= '0;
        end else if (m_fire) begin
            if (final_member) begin
                full_q <= 1'b0;
            end
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // s_fire and m_fire never coincide since a full buffer refuses input
    always_ff @(posedge aclk) begin
        if (s_fire) begin
            buf_q  <= s_data;
            last_q <= s_last;
        end else if (m_fire) begin
            buf_q <= buf_q >> GROUP_W;  // next group drops into the lsbs
        end
    end

    // a stalled narrow beat must not change under the engine
    a_stable_on_stall: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (m.valid && !m.ready) |=> (m.valid && $stable(m.data) && $stable(m.last))
    );

endmodule

//--- verilog/axis_lrelu_top.sv
module axis_lrelu_top #(
    parameter int UNITS   = lrelu_pkg::DEF_UNITS,
    parameter int MEMBERS = lrelu_pkg::DEF_MEMBERS
) (
    input  logic                                aclk,
    input  logic                                arst_n,
    input  logic                                s_axis_tvalid,
    output logic                                s_axis_tready,
    input  lrelu_pkg::acc_t [MEMBERS*UNITS-1:0] s_axis_tdata,   // config or data, wide
    input  logic                                s_axis_tlast,
    output logic                                m_axis_tvalid,
    input  logic                                m_axis_tready,
    output lrelu_pkg::out_t [UNITS-1:0]         m_axis_tdata,   // narrow output words
    output logic                                m_axis_tlast
);

    logic dw_valid;  // steered input valid
    logic dw_ready;

    lrelu_beat_if #(.UNITS(UNITS), .word_t(lrelu_pkg::acc_t)) dw_bus ();
    lrelu_beat_if #(.UNITS(UNITS), .word_t(lrelu_pkg::out_t)) eng_bus ();
    lrelu_beat_if #(.UNITS(UNITS), .word_t(lrelu_pkg::out_t)) out_bus ();
    lrelu_cfg_if  #(.UNITS(UNITS))                            cfg_bus ();

    assign m_axis_tvalid = out_bus.valid;
    assign m_axis_tdata  = out_bus.data;
    assign m_axis_tlast  = out_bus.last;
    assign out_bus.ready = m_axis_tready;

    // the controller also watches the output to know when the iteration is done
    lrelu_config_ctrl #(.UNITS(UNITS), .MEMBERS(MEMBERS)) u_ctrl (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tlast  (s_axis_tlast),
        .dw_valid      (dw_valid),
        .dw_ready      (dw_ready),
        .out_valid     (m_axis_tvalid),
        .out_ready     (m_axis_tready),
        .out_last      (m_axis_tlast),
        .cfg_bus       (cfg_bus)
    );

    axis_dw_down #(.UNITS(UNITS), .MEMBERS(MEMBERS)) u_dw (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .s_valid (dw_valid),
        .s_ready (dw_ready),
        .s_data  (s_axis_tdata),
        .s_last  (s_axis_tlast),
        .m       (dw_bus)
    );

    lrelu_engine #(.UNITS(UNITS)) u_engine (
        .aclk   (aclk),
        .arst_n (arst_n),
        .cfg    (cfg_bus),
        .s      (dw_bus),
        .m      (eng_bus)
    );

    axis_reg_slice #(.UNITS(UNITS)) u_slice (
        .aclk   (aclk),
        .arst_n (arst_n),
        .s      (eng_bus),
        .m      (out_bus)
    );

endmodule

//--- verilog/axis_reg_slice.sv
module axis_reg_slice #(
    parameter int UNITS = lrelu_pkg::DEF_UNITS
) (
    input  logic         aclk,
    input  logic         arst_n,
    lrelu_beat_if.sink   s,
    lrelu_beat_if.source m
);

    lrelu_pkg::out_t [UNITS-1:0] main_data_q;  // entry seen at the output
    lrelu_pkg::out_t [UNITS-1:0] skid_data_q;  // catches the beat accepted during a stall
    logic                        main_valid_q;
    logic                        main_last_q;
    logic                        skid_valid_q;
    logic                        skid_last_q;
    logic                        s_fire;
    logic                        load_main;

    assign s.ready   = !skid_valid_q;  // registered so the output ready path stops here
    assign s_fire    = s.valid && s.ready;
    assign load_main = m.ready || !main_valid_q;  // output entry free or leaving

    assign m.valid = main_valid_q;
    assign m.data  = main_data_q;
    assign m.last  = main_last_q;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            main_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (load_main) begin
            main_valid_q <= skid_valid_q || s.valid;  // skid entry goes first
            skid_valid_q <= 1'b0;
        end else if (s_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (load_main) begin
            main_data_q <= skid_valid_q ? skid_data_q : s.data;
            main_last_q <= skid_valid_q ? skid_last_q : s.last;
        end
        if (s_fire) begin
            skid_data_q <= s.data;  // only kept when the output is stalled
            skid_last_q <= s.last;
        end
    end

    // a parked skid beat always has an older beat waiting ahead of it
    a_skid_behind_main: assert property (
        @(posedge aclk) disable iff (!arst_n)
        skid_valid_q |-> main_valid_q
    );

endmodule

//--- verilog/lrelu_beat_if.sv
interface lrelu_beat_if #(
    parameter int  UNITS  = lrelu_pkg::DEF_UNITS,
    parameter type word_t = lrelu_pkg::acc_t     // acc_t before the engine, out_t after it
) ();

    logic                valid;  // beat present
    logic                ready;  // sink takes the beat on this edge
    word_t [UNITS-1:0]   data;   // UNITS words, word 0 in the lsbs
    logic                last;   // final beat of the iteration

    // producer side
    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

//--- verilog/lrelu_cfg_if.sv
interface lrelu_cfg_if #(
    parameter int UNITS = lrelu_pkg::DEF_UNITS
) ();

    // fields are only meaningful in the cycle where load is high
    logic                           load;   // one cycle strobe on the config transfer
    lrelu_pkg::acc_t   [UNITS-1:0]  bias;   // added before the multiply
    lrelu_pkg::scale_t [UNITS-1:0]  scale;  // per unit multiplier
    lrelu_pkg::shift_t              shift;  // shared requant shift

    modport ctrl (
        output load,
        output bias,
        output scale,
        output shift
    );

    // engine copies the fields into its own registers
    modport engine (
        input  load,
        input  bias,
        input  scale,
        input  shift
    );

endinterface

//--- verilog/lrelu_config_ctrl.sv
module lrelu_config_ctrl #(
    parameter int UNITS   = lrelu_pkg::DEF_UNITS,
    parameter int MEMBERS = lrelu_pkg::DEF_MEMBERS
) (
    input  logic                                aclk,
    input  logic                                arst_n,
    input  logic                                s_axis_tvalid,
    output logic                                s_axis_tready,
    input  lrelu_pkg::acc_t [MEMBERS*UNITS-1:0] s_axis_tdata,
    input  logic                                s_axis_tlast,
    output logic                                dw_valid,   // valid toward the converter
    input  logic                                dw_ready,
    input  logic                                out_valid,  // top output stream watched for its tlast
    input  logic                                out_ready,
    input  logic                                out_last,
    lrelu_cfg_if.ctrl                           cfg_bus
);

    lrelu_pkg::ctrl_state_t state_q;
    lrelu_pkg::ctrl_state_t state_d;
    logic                   in_fire;
    logic                   out_last_fire;

    // the config words have to fit inside one wide beat
    if (MEMBERS * UNITS < 2 * UNITS + 1) begin : g_layout_check
        $error("config beat needs at least 2*UNITS+1 words");
    end

    assign in_fire       = s_axis_tvalid && s_axis_tready;
    assign out_last_fire = out_valid && out_ready && out_last;  // last word left the top

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= lrelu_pkg::WRITE_S;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            lrelu_pkg::WRITE_S: begin
                if (in_fire) begin
                    state_d = lrelu_pkg::PASS_S;  // exactly one config beat per iteration
                end
            end
            lrelu_pkg::PASS_S: begin
                if (in_fire && s_axis_tlast) begin
                    state_d = lrelu_pkg::BLOCK_S;
                end
            end
            lrelu_pkg::BLOCK_S: begin
                // everything in flight has drained once the output tlast goes out
                if (out_last_fire) begin
                    state_d = lrelu_pkg::WRITE_S;
                end
            end
            default: state_d = lrelu_pkg::WRITE_S;
        endcase
    end

    // the selected consumer owns the input handshake
    always_comb begin
        s_axis_tready = 1'b0;
        dw_valid      = 1'b0;
        cfg_bus.load  = 1'b0;
        case (state_q)
            lrelu_pkg::WRITE_S: begin
                s_axis_tready = 1'b1;           // config capture never stalls
                cfg_bus.load  = s_axis_tvalid;  // so valid alone marks the transfer
            end
            lrelu_pkg::PASS_S: begin
                dw_valid      = s_axis_tvalid;
                s_axis_tready = dw_ready;
            end
            default: begin
                s_axis_tready = 1'b0;  // blocked while the previous iteration drains
            end
        endcase
    end

    // slice the config beat straight from the input bus
    always_comb begin
        for (int u = 0; u < UNITS; u++) begin
            cfg_bus.bias[u]  = s_axis_tdata[u];
            cfg_bus.scale[u] = s_axis_tdata[UNITS+u][7:0];
        end
        cfg_bus.shift = s_axis_tdata[2*UNITS][3:0];
    end

    // the input closes on the edge that takes the data tlast of the iteration
    a_closed_after_tlast: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (state_q == lrelu_pkg::PASS_S && in_fire && s_axis_tlast) |=> !s_axis_tready
    );

endmodule

//--- verilog/lrelu_engine.sv
module lrelu_engine #(
    parameter int UNITS = lrelu_pkg::DEF_UNITS
) (
    input  logic         aclk,
    input  logic         arst_n,
    lrelu_cfg_if.engine  cfg,
    lrelu_beat_if.sink   s,
    lrelu_beat_if.source m
);

    lrelu_pkg::acc_t   [UNITS-1:0] bias_q;
    lrelu_pkg::scale_t [UNITS-1:0] scale_q;
    lrelu_pkg::shift_t             shift_q;
    lrelu_pkg::prod_t  [UNITS-1:0] prod_d;
    lrelu_pkg::prod_t  [UNITS-1:0] prod_q;  // stage 1 result
    lrelu_pkg::out_t   [UNITS-1:0] out_d;
    lrelu_pkg::out_t   [UNITS-1:0] out_q;   // stage 2 result
    logic                          en;
    logic                          v1_q;
    logic                          v2_q;
    logic                          last1_q;
    logic                          last2_q;

    // shift, leak and clamp one product to a signed byte
    function automatic lrelu_pkg::out_t requant(
        input lrelu_pkg::prod_t  p,
        input lrelu_pkg::shift_t sh
    );
        lrelu_pkg::prod_t v;
        v = p >>> sh;
        if (v < 0) begin
            v = v >>> lrelu_pkg::LEAK_SHIFT;  // leaky slope of 1/8
        end
        if (v > 127) begin
            return 8'sh7f;
        end else if (v < -128) begin
            return 8'sh80;
        end
        return v[7:0];
    endfunction

    assign en      = m.ready;  // whole pipeline freezes when the slice is full
    assign s.ready = en;
    assign m.valid = v2_q;
    assign m.data  = out_q;
    assign m.last  = last2_q;

    // config is copied once per iteration while the pipeline is empty
    always_ff @(posedge aclk) begin
        if (cfg.load) begin
            bias_q  <= cfg.bias;
            scale_q <= cfg.scale;
            shift_q <= cfg.shift;
        end
    end

    // stage 1 math, bias add then multiply
    always_comb begin
        logic signed [16:0] sum;
        for (int u = 0; u < UNITS; u++) begin
            sum       = 17'(s.data[u]) + 17'(bias_q[u]);  // cannot overflow 17 bits
            prod_d[u] = lrelu_pkg::prod_t'(sum)
                        * lrelu_pkg::prod_t'(signed'({1'b0, scale_q[u]}));
        end
    end

    // stage 2 math
    always_comb begin
        for (int u = 0; u < UNITS; u++) begin
            out_d[u] = requant(prod_q[u], shift_q);
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else if (en) begin
            v1_q <= s.valid;  // bubbles travel too
            v2_q <= v1_q;
        end
    end

    always_ff @(posedge aclk) begin
        if (en) begin
            prod_q  <= prod_d;
            last1_q <= s.last;
            out_q   <= out_d;
            last2_q <= last1_q;
        end
    end

    // the controller only loads after the previous iteration has fully drained
    a_load_when_empty: assert property (
        @(posedge aclk) disable iff (!arst_n)
        cfg.load |-> !(s.valid || v1_q || v2_q)
    );

endmodule

//--- verilog/lrelu_pkg.sv
package lrelu_pkg;

    // word types of the datapath
    typedef logic signed [15:0] acc_t;    // one accumulator word from the conv engine
    typedef logic signed [7:0]  out_t;    // one requantized word after the leaky relu
    typedef logic        [7:0]  scale_t;  // unsigned per-unit multiplier
    typedef logic        [3:0]  shift_t;  // global arithmetic right shift
    typedef logic signed [25:0] prod_t;   // 17 bit sum times 9 bit signed scale fits here

    // iteration states of the config controller
    typedef enum logic [1:0] {
        WRITE_S,  // waits for the single config beat and is entered on reset
        PASS_S,   // data beats go through the width converter
        BLOCK_S   // input held off until the output tlast has left
    } ctrl_state_t;

    localparam int DEF_UNITS   = 2;  // words per narrow beat
    localparam int DEF_MEMBERS = 4;  // narrow beats packed into one wide beat

    // negative values get a slope of 1/8
    localparam int LEAK_SHIFT = 3;

    // the config beat reuses the wide data layout, word index w counts from the lsb
    //   word u             holds bias u for u below UNITS
    //   word UNITS+u       holds scale u in its low 8 bits
    //   word 2*UNITS       holds the shift in its low 4 bits
    // so a wide beat must carry at least 2*UNITS+1 words
    // all other words of the config beat are ignored

endpackage
